//--- rtl/fifo_pkg.sv
// shared definitions for the five-entry FIFO
// depth, entry width and counter limits
// vector typedefs for entries, slot indices, occupancy and drop count

package fifo_pkg;

  // ------------------------------------------------------------------------
  // sizes and limits
  // ------------------------------------------------------------------------

  // number of entries, deliberately not a power of two
  localparam int fifo_depth = 5;
  localparam int data_width = 8;

  // last valid slot index, pointers wrap after it
  localparam int ptr_max = fifo_depth - 1;

  // drop counter holds here once reached
  localparam int drop_max = 15;

  // derived vector widths
  localparam int ptr_width = $clog2(fifo_depth);
  localparam int count_width = $clog2(fifo_depth + 1);
  localparam int drop_width = $clog2(drop_max + 1);

  // ------------------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------------------

  typedef logic [data_width-1:0] data_t;
  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [count_width-1:0] count_t;
  typedef logic [drop_width-1:0] drop_t;

endpackage

//--- rtl/counter_incr.sv
// generic incrementing counter
// adds one per valid cycle up to an inclusive limit
// wraps to zero or saturates at the limit, chosen by parameter
// separate reinit port loads zero without touching reset

module counter_incr #(
  // inclusive upper limit, at least 1
  parameter int unsigned max_value = 1,
  // 0 wraps to zero past the limit, 1 holds at the limit
  parameter bit saturate = 0
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 reinit,
  input  logic                                 incr_valid,
  output logic [$clog2(max_value + 1)-1:0]     value
);

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  localparam int value_width = $clog2(max_value + 1);
  // one extra bit so the sum past the limit is still visible
  localparam int sum_width = value_width + 1;

  logic [sum_width-1:0]   value_sum;
  logic [value_width-1:0] value_limit;
  logic [value_width-1:0] value_next;

  // ------------------------------------------------------------------------
  // next value
  // ------------------------------------------------------------------------

  // widened sum of current value plus one
  assign value_sum = {1'b0, value} + sum_width'(1);

  // limit as a value-wide vector for the saturating case
  assign value_limit = value_width'(max_value);

  // explicit compare handles limits where max_value + 1 is not a power of two
  always_comb begin
    if (value_sum > sum_width'(max_value)) begin
      if (saturate) begin
        value_next = value_limit;
      end else begin
        value_next = '0;
      end
    end else begin
      value_next = value_sum[value_width-1:0];
    end
  end

  // ------------------------------------------------------------------------
  // state
  // ------------------------------------------------------------------------

  // reinit takes precedence and drops any increment in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= '0;
    end else if (reinit) begin
      value <= '0;
    end else if (incr_valid) begin
      value <= value_next;
    end
  end

endmodule

//--- rtl/fifo_mem.sv
// FIFO storage array
// five entries, one synchronous write port
// one combinational read port indexed by slot

module fifo_mem
  import fifo_pkg::*;
(
  input  logic  clk,
  input  logic  wr_en,
  input  ptr_t  wr_addr,
  input  data_t wr_data,
  input  ptr_t  rd_addr,
  output data_t rd_data
);

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------

  // contents are undefined until a slot is first written
  data_t mem [fifo_depth];

  // write lands at the edge where wr_en is high
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ------------------------------------------------------------------------
  // read
  // ------------------------------------------------------------------------

  // zero latency from address to data
  // rd_addr stays within 0 to ptr_max so the index is always in range
  assign rd_data = mem[rd_addr];

endmodule

//--- rtl/fifo_ctrl.sv
// FIFO control
// push and pop acceptance from the registered occupancy
// write and read pointer counters wrapping at the last slot
// saturating counter of pushes refused while full
// occupancy register with full and empty decode

module fifo_ctrl
  import fifo_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  logic   pop,
  input  logic   flush,
  output logic   wr_en,
  output ptr_t   wr_addr,
  output ptr_t   rd_addr,
  output logic   empty,
  output logic   full,
  output count_t count,
  output drop_t  drop_count
);

  // ------------------------------------------------------------------------
  // acceptance
  // ------------------------------------------------------------------------

  logic push_ok;
  logic pop_ok;
  logic push_drop;

  // status flags come straight from the occupancy register
  assign empty = (count == '0);
  assign full = (count == count_t'(fifo_depth));

  // flush wins over both strobes in the same cycle
  // push is judged on full before the edge, even if a pop frees a slot
  assign push_ok = push && !full && !flush;
  assign pop_ok = pop && !empty && !flush;

  // refused push, counted but never written
  assign push_drop = push && full && !flush;

  // memory writes only for accepted pushes
  assign wr_en = push_ok;

  // ------------------------------------------------------------------------
  // counters
  // ------------------------------------------------------------------------

  // write slot, wraps 4 back to 0
  counter_incr #(
    .max_value (ptr_max),
    .saturate  (1'b0)
  ) wr_ptr_ctr (
    .clk        (clk),
    .rst_n      (rst_n),
    .reinit     (flush),
    .incr_valid (push_ok),
    .value      (wr_addr)
  );

  // read slot, always points at the oldest entry
  counter_incr #(
    .max_value (ptr_max),
    .saturate  (1'b0)
  ) rd_ptr_ctr (
    .clk        (clk),
    .rst_n      (rst_n),
    .reinit     (flush),
    .incr_valid (pop_ok),
    .value      (rd_addr)
  );

  // refused pushes, held at drop_max
  counter_incr #(
    .max_value (drop_max),
    .saturate  (1'b1)
  ) drop_ctr (
    .clk        (clk),
    .rst_n      (rst_n),
    .reinit     (flush),
    .incr_valid (push_drop),
    .value      (drop_count)
  );

  // ------------------------------------------------------------------------
  // occupancy
  // ------------------------------------------------------------------------

  // push alone adds one, pop alone removes one, both together hold
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else if (push_ok && !pop_ok) begin
      count <= count + count_t'(1);
    end else if (pop_ok && !push_ok) begin
      count <= count - count_t'(1);
    end
  end

endmodule

//--- rtl/fifo_top.sv
// top level of the five-entry FIFO
// control block with pointer and drop counters
// storage array with combinational head read

module fifo_top
  import fifo_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  data_t  push_data,
  input  logic   pop,
  input  logic   flush,
  output data_t  head_data,
  output logic   empty,
  output logic   full,
  output count_t count,
  output drop_t  drop_count
);

  // ------------------------------------------------------------------------
  // control to storage
  // ------------------------------------------------------------------------

  logic wr_en;
  ptr_t wr_addr;
  ptr_t rd_addr;

  fifo_ctrl ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .pop        (pop),
    .flush      (flush),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .rd_addr    (rd_addr),
    .empty      (empty),
    .full       (full),
    .count      (count),
    .drop_count (drop_count)
  );

  // head_data is only meaningful while empty is low
  fifo_mem mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (push_data),
    .rd_addr (rd_addr),
    .rd_data (head_data)
  );

endmodule

//--- testbench/tb_fifo.sv
// testbench for the five-entry FIFO
// clock, reset and a Galois LFSR for entry data
// queue model of contents, occupancy and drop count
// directed tests for reset, wrap, overflow, push with pop, and flush
// cycle limit and closing summary

module tb_fifo
  import fifo_pkg::*;
;

  // ------------------------------------------------------------------------
  // DUT signals
  // ------------------------------------------------------------------------

  logic   clk;
  logic   rst_n;
  logic   push;
  data_t  push_data;
  logic   pop;
  logic   flush;
  data_t  head_data;
  logic   empty;
  logic   full;
  count_t count;
  drop_t  drop_count;

  fifo_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .flush      (flush),
    .head_data  (head_data),
    .empty      (empty),
    .full       (full),
    .count      (count),
    .drop_count (drop_count)
  );

  // ------------------------------------------------------------------------
  // model and bookkeeping
  // ------------------------------------------------------------------------

  // the whole run takes a few hundred cycles at most, so this is a wide margin
  localparam int cycle_limit = 2000;

  data_t       model_q[$];
  int          model_drops;
  logic [31:0] lfsr_state;
  int          cycle_count;
  int          error_count;
  int          errors_at_start;
  int          tests_passed;
  int          tests_failed;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run limit, counts every rising edge from time zero
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == cycle_limit) begin
      $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // right-shift Galois form, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // eight steps, one bit taken from each
  function automatic data_t random_byte();
    data_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  task automatic report_mismatch(input string what, input int expected, input int actual);
    $display("** Error at %0t: %s expected %0h, got %0h", $time, what, expected, actual);
    error_count = error_count + 1;
  endtask

  // compare every output against the model
  task automatic check_outputs();
    logic   exp_empty;
    logic   exp_full;
    count_t exp_count;
    drop_t  exp_drops;
    exp_empty = (model_q.size() == 0);
    exp_full = (model_q.size() == fifo_depth);
    exp_count = count_t'(model_q.size());
    exp_drops = drop_t'(model_drops);
    if (empty !== exp_empty) report_mismatch("empty", int'(exp_empty), int'(empty));
    if (full !== exp_full) report_mismatch("full", int'(exp_full), int'(full));
    if (count !== exp_count) report_mismatch("count", int'(exp_count), int'(count));
    if (drop_count !== exp_drops) begin
      report_mismatch("drop_count", int'(exp_drops), int'(drop_count));
    end
    // head is only defined while something is stored
    if (!exp_empty) begin
      if (head_data !== model_q[0]) begin
        report_mismatch("head_data", int'(model_q[0]), int'(head_data));
      end
    end
  endtask

  // one clock: drive strobes, step the model, check after the edge
  // called 10 units past a rising edge
  task automatic drive_cycle(input logic do_push, input data_t data,
                             input logic do_pop, input logic do_flush);
    logic was_full;
    logic was_empty;
    push = do_push;
    push_data = data;
    pop = do_pop;
    flush = do_flush;
    // acceptance is judged on the state before the edge
    was_full = (model_q.size() == fifo_depth);
    was_empty = (model_q.size() == 0);
    if (do_flush) begin
      model_q.delete();
      model_drops = 0;
    end else begin
      if (do_pop && !was_empty) void'(model_q.pop_front());
      if (do_push) begin
        if (!was_full) begin
          model_q.push_back(data);
        end else if (model_drops < drop_max) begin
          model_drops = model_drops + 1;
        end
      end
    end
    @(posedge clk);
    #10;
    check_outputs();
    push = 1'b0;
    pop = 1'b0;
    flush = 1'b0;
  endtask

  task automatic push_entry(input data_t data);
    drive_cycle(1'b1, data, 1'b0, 1'b0);
  endtask

  task automatic pop_entry();
    drive_cycle(1'b0, '0, 1'b1, 1'b0);
  endtask

  task automatic begin_test();
    errors_at_start = error_count;
  endtask

  task automatic end_test(input string name);
    if (error_count == errors_at_start) begin
      $display("%s: ok", name);
      tests_passed = tests_passed + 1;
    end else begin
      $display("%s: FAILED with %0d errors", name, error_count - errors_at_start);
      tests_failed = tests_failed + 1;
    end
  endtask

  // ------------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------------

  task automatic test_reset_state();
    begin_test();
    check_outputs();
    drive_cycle(1'b0, '0, 1'b0, 1'b0);
    end_test("reset state");
  endtask

  // five in, five out, three times, so both pointers wrap 4 to 0 each round
  task automatic test_fill_drain();
    begin_test();
    for (int round = 0; round < 3; round++) begin
      repeat (fifo_depth) push_entry(random_byte());
      if (full !== 1'b1) report_mismatch("full after five pushes", 1, int'(full));
      if (count !== 3'd5) report_mismatch("count after five pushes", 5, int'(count));
      repeat (fifo_depth) pop_entry();
      if (empty !== 1'b1) report_mismatch("empty after drain", 1, int'(empty));
    end
    end_test("fill and drain through wrap");
  endtask

  // twenty refused pushes, drop count saturates, stored data survives
  task automatic test_overflow();
    begin_test();
    repeat (fifo_depth) push_entry(random_byte());
    repeat (20) push_entry(random_byte());
    if (drop_count !== 4'd15) begin
      report_mismatch("drop_count after overflow", 15, int'(drop_count));
    end
    repeat (fifo_depth) pop_entry();
    end_test("overflow while full");
  endtask

  task automatic test_push_with_pop();
    begin_test();
    // clear the saturated drop count first
    drive_cycle(1'b0, '0, 1'b0, 1'b1);
    // empty, pop ignored and push taken
    drive_cycle(1'b1, random_byte(), 1'b1, 1'b0);
    if (count !== 3'd1) report_mismatch("count after push and pop at 0", 1, int'(count));
    push_entry(random_byte());
    // at two, occupancy holds and order is kept
    drive_cycle(1'b1, random_byte(), 1'b1, 1'b0);
    drive_cycle(1'b1, random_byte(), 1'b1, 1'b0);
    if (count !== 3'd2) report_mismatch("count after push and pop at 2", 2, int'(count));
    while (model_q.size() < fifo_depth) push_entry(random_byte());
    // full, pop taken but push still refused
    drive_cycle(1'b1, random_byte(), 1'b1, 1'b0);
    if (count !== 3'd4) report_mismatch("count after push and pop at full", 4, int'(count));
    if (drop_count !== 4'd1) begin
      report_mismatch("drop_count after push and pop at full", 1, int'(drop_count));
    end
    while (model_q.size() > 0) pop_entry();
    end_test("simultaneous push and pop");
  endtask

  task automatic test_flush();
    data_t late_data;
    begin_test();
    while (model_q.size() < fifo_depth) push_entry(random_byte());
    repeat (2) push_entry(random_byte());
    // pop one so the read and write pointers differ at the flush
    pop_entry();
    // flush beats the push and pop beside it
    drive_cycle(1'b1, random_byte(), 1'b1, 1'b1);
    if (empty !== 1'b1) report_mismatch("empty after flush", 1, int'(empty));
    if (count !== 3'd0) report_mismatch("count after flush", 0, int'(count));
    if (drop_count !== 4'd0) report_mismatch("drop_count after flush", 0, int'(drop_count));
    late_data = random_byte();
    push_entry(late_data);
    if (head_data !== late_data) begin
      report_mismatch("head_data after flush", int'(late_data), int'(head_data));
    end
    pop_entry();
    end_test("flush");
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    rst_n = 1'b0;
    push = 1'b0;
    push_data = '0;
    pop = 1'b0;
    flush = 1'b0;
    lfsr_state = 32'h160d;
    model_drops = 0;
    cycle_count = 0;
    error_count = 0;
    errors_at_start = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;
    test_reset_state();
    test_fill_drain();
    test_overflow();
    test_push_with_pop();
    test_flush();
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
rtl/fifo_pkg.sv
rtl/counter_incr.sv
rtl/fifo_mem.sv
rtl/fifo_ctrl.sv
rtl/fifo_top.sv
testbench/tb_fifo.sv

//--- Makefile
# Verilator build and run for the five-entry FIFO

TOP = tb_fifo

.PHONY: all lint clean

# build, run, and fail when the log reports a failed check
all: obj_dir/V$(TOP)
	@./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" sim.log; then \
	  echo "simulation reported failure"; exit 1; \
	fi

obj_dir/V$(TOP): files.f rtl/*.sv testbench/*.sv
	verilator --binary --timing --top-module $(TOP) -f files.f

lint:
	verilator --lint-only -Wall --top-module fifo_top \
	  rtl/fifo_pkg.sv rtl/counter_incr.sv rtl/fifo_mem.sv \
	  rtl/fifo_ctrl.sv rtl/fifo_top.sv

clean:
	rm -rf obj_dir sim.log
